//--- src/l1_macros.svh
`ifndef L1_MACROS_SVH
`define L1_MACROS_SVH

// Cache geometry
`define L1_NUM_WAYS     4
`define L1_NUM_SETS     16
`define L1_LINE_BYTES   16

// Physical address split, tag | set | offset
`define L1_PADDR_BITS   16
`define L1_OFFSET_BITS  4
`define L1_SET_BITS     4
`define L1_TAG_BITS     8

// Lookup pipe depth, MM0 through MM5
`define MM_NUM_STAGES   6

`endif

//--- src/rob_pkg.sv
`default_nettype none

package rob_pkg;

    // Reorder buffer entry id
    typedef logic [5:0] t_robid;

    // Physical register id in the integer PRF
    typedef logic [5:0] t_preg;

    // Integer register value
    typedef logic [63:0] t_reg_data;

endpackage

`default_nettype wire

//--- src/l1_cache_pkg.sv
`include "l1_macros.svh"

`default_nettype none

package l1_cache_pkg;

    typedef logic [`L1_PADDR_BITS-1:0]       t_paddr;
    typedef logic [`L1_SET_BITS-1:0]         t_l1_set;
    typedef logic [`L1_TAG_BITS-1:0]         t_l1_tag;
    typedef logic [`L1_OFFSET_BITS-1:0]      t_l1_offset;
    typedef logic [`L1_NUM_WAYS-1:0]         t_l1_way_vec;
    typedef logic [$clog2(`L1_NUM_WAYS)-1:0] t_l1_way;
    typedef logic [`L1_LINE_BYTES*8-1:0]     t_cl;

    // Stores held back by loads, observable count
    typedef logic [15:0] t_blk_cnt;

    typedef enum logic [1:0] {
        MESI_I = 2'd0,
        MESI_S = 2'd1,
        MESI_E = 2'd2,
        MESI_M = 2'd3
    } t_mesi;

    typedef enum logic {
        MEM_LOAD  = 1'b0,
        MEM_STORE = 1'b1
    } t_mem_kind;

    typedef struct packed {
        t_mem_kind        kind;
        t_paddr           addr;
        rob_pkg::t_robid  robid;
        rob_pkg::t_preg   preg;
    } t_mempipe_req;

    // Address field extraction
    function automatic t_l1_offset get_offset(t_paddr addr);
        return addr[`L1_OFFSET_BITS-1:0];
    endfunction

    function automatic t_l1_set get_set(t_paddr addr);
        return addr[`L1_OFFSET_BITS +: `L1_SET_BITS];
    endfunction

    function automatic t_l1_tag get_tag(t_paddr addr);
        return addr[`L1_PADDR_BITS-1 -: `L1_TAG_BITS];
    endfunction

endpackage

`default_nettype wire

//--- src/l1_array_if.sv
`include "l1_macros.svh"

`default_nettype none

interface l1_array_if;

    // Read request, driven in MM1
    l1_cache_pkg::t_l1_set  set_addr;
    logic                   rd_en;

    // Read data of all ways, valid in MM2
    l1_cache_pkg::t_l1_tag  rd_tags   [`L1_NUM_WAYS];
    l1_cache_pkg::t_mesi    rd_states [`L1_NUM_WAYS];
    l1_cache_pkg::t_cl      rd_lines  [`L1_NUM_WAYS];

    modport pipe (
        output set_addr,
        output rd_en,
        input  rd_tags,
        input  rd_states,
        input  rd_lines
    );

    modport arrays (
        input  set_addr,
        input  rd_en,
        output rd_tags,
        output rd_states,
        output rd_lines
    );

endinterface

`default_nettype wire

//--- src/mem_req_arbiter.sv
`default_nettype none

module mem_req_arbiter (
    input  logic                       clk,
    input  logic                       arst_n,

    input  logic                       ld_valid,
    output logic                       ld_ready,
    input  l1_cache_pkg::t_paddr       ld_addr,
    input  rob_pkg::t_robid            ld_robid,
    input  rob_pkg::t_preg             ld_preg,

    input  logic                       st_valid,
    output logic                       st_ready,
    input  l1_cache_pkg::t_paddr       st_addr,
    input  rob_pkg::t_robid            st_robid,

    output logic                       mm0_valid,
    output l1_cache_pkg::t_mempipe_req mm0_req,

    output l1_cache_pkg::t_blk_cnt     cnt_st_blocked
);

    // Store has lost arbitration at least once since it went valid
    logic st_held;

    // Fixed priority, load wins
    assign ld_ready  = ld_valid;
    assign st_ready  = st_valid & ~ld_valid;
    assign mm0_valid = ld_valid | st_valid;

    always_comb begin
        mm0_req.kind  = ld_valid ? l1_cache_pkg::MEM_LOAD : l1_cache_pkg::MEM_STORE;
        mm0_req.addr  = ld_valid ? ld_addr  : st_addr;
        mm0_req.robid = ld_valid ? ld_robid : st_robid;
        // Stores have no destination register
        mm0_req.preg  = ld_valid ? ld_preg  : '0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st_held        <= 1'b0;
            cnt_st_blocked <= '0;
        end else begin
            if (st_valid && ld_valid) begin
                st_held <= 1'b1;
            end else if (st_valid && st_ready) begin
                st_held <= 1'b0;
            end
            // Count a delayed store once, when it finally goes through
            if (st_valid && st_ready && st_held) begin
                cnt_st_blocked <= cnt_st_blocked + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/l1_set_arrays.sv
`include "l1_macros.svh"

`default_nettype none

module l1_set_arrays (
    input  logic                    clk,
    input  logic                    arst_n,

    l1_array_if.arrays              arr,

    input  logic                    fill_valid,
    output logic                    fill_ready,
    input  l1_cache_pkg::t_l1_set   fill_set,
    input  l1_cache_pkg::t_l1_way   fill_way,
    input  l1_cache_pkg::t_l1_tag   fill_tag,
    input  l1_cache_pkg::t_mesi     fill_state,
    input  l1_cache_pkg::t_cl       fill_line
);

    l1_cache_pkg::t_l1_tag  tags   [`L1_NUM_SETS][`L1_NUM_WAYS];
    l1_cache_pkg::t_mesi    states [`L1_NUM_SETS][`L1_NUM_WAYS];
    l1_cache_pkg::t_cl      lines  [`L1_NUM_SETS][`L1_NUM_WAYS];

    logic                   fill_acc;

    // Pipe reads take the array, fills wait
    assign fill_ready = ~arr.rd_en;
    assign fill_acc   = fill_valid & fill_ready;

    // MESI state per way, all invalid out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < `L1_NUM_SETS; s++) begin
                for (int w = 0; w < `L1_NUM_WAYS; w++) begin
                    states[s][w] <= l1_cache_pkg::MESI_I;
                end
            end
        end else if (fill_acc) begin
            states[fill_set][fill_way] <= fill_state;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_acc) begin
            tags[fill_set][fill_way]  <= fill_tag;
            lines[fill_set][fill_way] <= fill_line;
        end
    end

    // Registered set read of all ways
    always_ff @(posedge clk) begin
        if (arr.rd_en) begin
            for (int w = 0; w < `L1_NUM_WAYS; w++) begin
                arr.rd_tags[w]   <= tags[arr.set_addr][w];
                arr.rd_states[w] <= states[arr.set_addr][w];
                arr.rd_lines[w]  <= lines[arr.set_addr][w];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/mempipe.sv
`include "l1_macros.svh"

`default_nettype none

module mempipe (
    input  logic                        clk,
    input  logic                        arst_n,

    input  logic                        mm0_valid,
    input  l1_cache_pkg::t_mempipe_req  mm0_req,

    l1_array_if.pipe                    arr,

    output logic                        cpl_valid,
    output rob_pkg::t_robid             cpl_robid,
    output logic                        cpl_hit,
    output logic                        cpl_is_load,

    output logic                        wb_valid,
    output rob_pkg::t_preg              wb_preg,
    output rob_pkg::t_reg_data          wb_data
);

    // MM0 arb result, MM1 set read (no TLB), MM2 hit, MM3 way mux,
    // MM4 byte rotate, MM5 completion
    localparam int MM0 = 0;
    localparam int MM1 = 1;
    localparam int MM2 = 2;
    localparam int MM4 = 4;
    localparam int MM5 = `MM_NUM_STAGES - 1;

    localparam int REG_BYTES = $bits(rob_pkg::t_reg_data) / 8;

    logic                        valid_q [`MM_NUM_STAGES];
    l1_cache_pkg::t_mempipe_req  req_q   [`MM_NUM_STAGES];

    l1_cache_pkg::t_l1_way_vec   hit_vec_mm2;
    l1_cache_pkg::t_l1_way_vec   hit_vec_mm3;
    logic                        hit_mm3;
    logic                        hit_mm4;
    logic                        hit_mm5;
    l1_cache_pkg::t_cl           lines_mm3 [`L1_NUM_WAYS];
    l1_cache_pkg::t_cl           line_sel_mm3;
    l1_cache_pkg::t_cl           line_mm4;
    rob_pkg::t_reg_data          rot_mm4;
    rob_pkg::t_reg_data          rot_mm5;

    // Stage valids
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '{default: 1'b0};
        end else begin
            valid_q[MM0] <= mm0_valid;
            for (int s = 1; s < `MM_NUM_STAGES; s++) begin
                valid_q[s] <= valid_q[s-1];
            end
        end
    end

    // MM1 set read
    assign arr.rd_en    = valid_q[MM1];
    assign arr.set_addr = l1_cache_pkg::get_set(req_q[MM1].addr);

    // MM2 tag compare, stores need ownership
    always_comb begin
        for (int w = 0; w < `L1_NUM_WAYS; w++) begin
            hit_vec_mm2[w] = valid_q[MM2]
                & (arr.rd_tags[w] == l1_cache_pkg::get_tag(req_q[MM2].addr))
                & ((req_q[MM2].kind == l1_cache_pkg::MEM_LOAD)
                    ? (arr.rd_states[w] != l1_cache_pkg::MESI_I)
                    : (arr.rd_states[w] inside {l1_cache_pkg::MESI_E, l1_cache_pkg::MESI_M}));
        end
    end

    // MM3 AND-OR way select, hit vector is at most one-hot
    always_comb begin
        line_sel_mm3 = '0;
        for (int w = 0; w < `L1_NUM_WAYS; w++) begin
            line_sel_mm3 |= lines_mm3[w] & {$bits(l1_cache_pkg::t_cl){hit_vec_mm3[w]}};
        end
    end

    // MM4 pick eight bytes from the offset, wrapping inside the line
    always_comb begin
        l1_cache_pkg::t_l1_offset idx;
        idx = l1_cache_pkg::get_offset(req_q[MM4].addr);
        for (int b = 0; b < REG_BYTES; b++) begin
            rot_mm4[8*b +: 8] = line_mm4[8*idx +: 8];
            idx = idx + 1'b1;
        end
    end

    // Request packets and per-stage results
    always_ff @(posedge clk) begin
        req_q[MM0] <= mm0_req;
        for (int s = 1; s < `MM_NUM_STAGES; s++) begin
            req_q[s] <= req_q[s-1];
        end
        hit_vec_mm3 <= hit_vec_mm2;
        hit_mm3     <= |hit_vec_mm2;
        lines_mm3   <= arr.rd_lines;
        line_mm4    <= line_sel_mm3;
        hit_mm4     <= hit_mm3;
        rot_mm5     <= rot_mm4;
        hit_mm5     <= hit_mm4;
    end

    // MM5 completion and load writeback
    assign cpl_valid   = valid_q[MM5];
    assign cpl_robid   = req_q[MM5].robid;
    assign cpl_hit     = hit_mm5;
    assign cpl_is_load = req_q[MM5].kind == l1_cache_pkg::MEM_LOAD;

    assign wb_valid = valid_q[MM5] & cpl_is_load & hit_mm5;
    assign wb_preg  = req_q[MM5].preg;
    assign wb_data  = rot_mm5;

endmodule

`default_nettype wire

//--- src/l1_dcache_top.sv
`default_nettype none

module l1_dcache_top (
    input  logic                    clk,
    input  logic                    arst_n,

    // Load request
    input  logic                    ld_valid,
    output logic                    ld_ready,
    input  l1_cache_pkg::t_paddr    ld_addr,
    input  rob_pkg::t_robid         ld_robid,
    input  rob_pkg::t_preg          ld_preg,

    // Store request
    input  logic                    st_valid,
    output logic                    st_ready,
    input  l1_cache_pkg::t_paddr    st_addr,
    input  rob_pkg::t_robid         st_robid,

    // Line fill
    input  logic                    fill_valid,
    output logic                    fill_ready,
    input  l1_cache_pkg::t_l1_set   fill_set,
    input  l1_cache_pkg::t_l1_way   fill_way,
    input  l1_cache_pkg::t_l1_tag   fill_tag,
    input  l1_cache_pkg::t_mesi     fill_state,
    input  l1_cache_pkg::t_cl       fill_line,

    // ROB completion
    output logic                    cpl_valid,
    output rob_pkg::t_robid         cpl_robid,
    output logic                    cpl_hit,
    output logic                    cpl_is_load,

    // Register file write
    output logic                    wb_valid,
    output rob_pkg::t_preg          wb_preg,
    output rob_pkg::t_reg_data      wb_data,

    output l1_cache_pkg::t_blk_cnt  cnt_st_blocked
);

    logic                        mm0_valid;
    l1_cache_pkg::t_mempipe_req  mm0_req;

    l1_array_if arr_if ();

    mem_req_arbiter u_arb (
        .clk            (clk),
        .arst_n         (arst_n),
        .ld_valid       (ld_valid),
        .ld_ready       (ld_ready),
        .ld_addr        (ld_addr),
        .ld_robid       (ld_robid),
        .ld_preg        (ld_preg),
        .st_valid       (st_valid),
        .st_ready       (st_ready),
        .st_addr        (st_addr),
        .st_robid       (st_robid),
        .mm0_valid      (mm0_valid),
        .mm0_req        (mm0_req),
        .cnt_st_blocked (cnt_st_blocked)
    );

    mempipe u_pipe (
        .clk         (clk),
        .arst_n      (arst_n),
        .mm0_valid   (mm0_valid),
        .mm0_req     (mm0_req),
        .arr         (arr_if.pipe),
        .cpl_valid   (cpl_valid),
        .cpl_robid   (cpl_robid),
        .cpl_hit     (cpl_hit),
        .cpl_is_load (cpl_is_load),
        .wb_valid    (wb_valid),
        .wb_preg     (wb_preg),
        .wb_data     (wb_data)
    );

    l1_set_arrays u_arrays (
        .clk        (clk),
        .arst_n     (arst_n),
        .arr        (arr_if.arrays),
        .fill_valid (fill_valid),
        .fill_ready (fill_ready),
        .fill_set   (fill_set),
        .fill_way   (fill_way),
        .fill_tag   (fill_tag),
        .fill_state (fill_state),
        .fill_line  (fill_line)
    );

endmodule

`default_nettype wire

//--- bench/tb_l1_dcache.sv
`default_nettype none

module tb_l1_dcache;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    CLK_PERIOD        = 20;
    localparam int    DRIVE_DLY         = 2;
    localparam int    RESET_CYCLES      = 4;
    localparam int    LATENCY           = 5;
    localparam int    CYCLES_PER_RECORD = 40;
    localparam int    MAX_OPS           = 64;
    localparam string GOLDEN_FILE       = "bench/l1_golden.txt";

    logic                         clk;
    logic                         arst_n;
    logic                         ld_valid;
    logic                         ld_ready;
    l1_cache_pkg::t_paddr         ld_addr;
    rob_pkg::t_robid              ld_robid;
    rob_pkg::t_preg               ld_preg;
    logic                         st_valid;
    logic                         st_ready;
    l1_cache_pkg::t_paddr         st_addr;
    rob_pkg::t_robid              st_robid;
    logic                         fill_valid;
    logic                         fill_ready;
    l1_cache_pkg::t_l1_set        fill_set;
    l1_cache_pkg::t_l1_way        fill_way;
    l1_cache_pkg::t_l1_tag        fill_tag;
    l1_cache_pkg::t_mesi          fill_state;
    l1_cache_pkg::t_cl            fill_line;
    logic                         cpl_valid;
    rob_pkg::t_robid              cpl_robid;
    logic                         cpl_hit;
    logic                         cpl_is_load;
    logic                         wb_valid;
    rob_pkg::t_preg               wb_preg;
    rob_pkg::t_reg_data           wb_data;
    l1_cache_pkg::t_blk_cnt       cnt_st_blocked;

    // Golden records, one op per F or R record
    logic [7:0]                   op_type [MAX_OPS];
    l1_cache_pkg::t_l1_set        f_set   [MAX_OPS];
    l1_cache_pkg::t_l1_way        f_way   [MAX_OPS];
    l1_cache_pkg::t_l1_tag        f_tag   [MAX_OPS];
    logic [1:0]                   f_state [MAX_OPS];
    l1_cache_pkg::t_cl            f_line  [MAX_OPS];
    logic                         r_kind  [MAX_OPS];
    l1_cache_pkg::t_paddr         r_addr  [MAX_OPS];
    rob_pkg::t_robid              r_robid [MAX_OPS];
    rob_pkg::t_preg               r_preg  [MAX_OPS];
    logic [1:0]                   r_sync  [MAX_OPS];
    logic                         e_hit   [MAX_OPS];
    rob_pkg::t_reg_data           e_data  [MAX_OPS];

    int                           n_ops;
    int                           n_records;
    int                           n_pairs;
    bit                           loaded;
    int                           cyc;
    logic [7:0]                   lfsr_state;

    // In-flight requests, op index and acceptance cycle
    int                           sb_idx [$];
    int                           sb_cyc [$];

    l1_dcache_top u_l1_dcache_top (
        .clk            (clk),
        .arst_n         (arst_n),
        .ld_valid       (ld_valid),
        .ld_ready       (ld_ready),
        .ld_addr        (ld_addr),
        .ld_robid       (ld_robid),
        .ld_preg        (ld_preg),
        .st_valid       (st_valid),
        .st_ready       (st_ready),
        .st_addr        (st_addr),
        .st_robid       (st_robid),
        .fill_valid     (fill_valid),
        .fill_ready     (fill_ready),
        .fill_set       (fill_set),
        .fill_way       (fill_way),
        .fill_tag       (fill_tag),
        .fill_state     (fill_state),
        .fill_line      (fill_line),
        .cpl_valid      (cpl_valid),
        .cpl_robid      (cpl_robid),
        .cpl_hit        (cpl_hit),
        .cpl_is_load    (cpl_is_load),
        .wb_valid       (wb_valid),
        .wb_preg        (wb_preg),
        .wb_data        (wb_data),
        .cnt_st_blocked (cnt_st_blocked)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        cyc = 0;
        forever begin
            @(posedge clk);
            cyc = cyc + 1;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic golden_error(input string why);
        $display("Golden file problem: %s", why);
        $display("TEST FAILED");
        $fatal(1, "bad golden file");
    endtask

    // 8-bit Galois LFSR, taps 0xB8
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        logic [7:0] n;
        n = {1'b0, s[7:1]};
        if (s[0]) begin
            n = n ^ 8'hB8;
        end
        return n;
    endfunction

    task automatic load_golden();
        int             fd;
        int             code;
        int             last_r;
        logic [7:0]     ch;
        logic [1023:0]  rest;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            golden_error("cannot open bench/l1_golden.txt");
        end
        last_r = -1;
        code = $fscanf(fd, " %c", ch);
        while (code == 1) begin
            if (n_ops >= MAX_OPS) begin
                golden_error("too many records");
            end
            if (ch == "#") begin
                code = $fgets(rest, fd);
            end else if (ch == "F" || ch == "R") begin
                if (last_r >= 0) begin
                    golden_error("R record without its E record");
                end
                op_type[n_ops] = ch;
                if (ch == "F") begin
                    code = $fscanf(fd, " %h %h %h %h %h", f_set[n_ops], f_way[n_ops],
                                   f_tag[n_ops], f_state[n_ops], f_line[n_ops]);
                end else begin
                    code = $fscanf(fd, " %h %h %h %h %h", r_kind[n_ops], r_addr[n_ops],
                                   r_robid[n_ops], r_preg[n_ops], r_sync[n_ops]);
                    last_r = n_ops;
                    if (r_sync[n_ops] == 2'd2) begin
                        n_pairs++;
                    end
                end
                if (code != 5) begin
                    golden_error("short F or R record");
                end
                n_ops++;
                n_records++;
            end else if (ch == "E") begin
                if (last_r < 0) begin
                    golden_error("E record with no R record before it");
                end
                code = $fscanf(fd, " %h %h", e_hit[last_r], e_data[last_r]);
                if (code != 2) begin
                    golden_error("short E record");
                end
                last_r = -1;
                n_records++;
            end else begin
                golden_error("unknown record type");
            end
            code = $fscanf(fd, " %c", ch);
        end
        $fclose(fd);
        if (last_r >= 0 || n_ops == 0) begin
            golden_error("file is empty or ends without an E record");
        end
    endtask

    // 0 to 3 idle cycles, two LFSR bits
    task automatic idle_gap();
        int n;
        n = 0;
        for (int b = 0; b < 2; b++) begin
            n = 2 * n + int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic wait_drained();
        while (sb_idx.size() != 0) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic apply_fill(input int i);
        wait_drained();
        fill_set   = f_set[i];
        fill_way   = f_way[i];
        fill_tag   = f_tag[i];
        fill_state = l1_cache_pkg::t_mesi'(f_state[i]);
        fill_line  = f_line[i];
        fill_valid = 1'b1;
        @(negedge clk);
        while (!fill_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DLY;
        fill_valid = 1'b0;
    endtask

    // One request, or a load and a store together when b is not negative
    task automatic send_requests(input int a, input int b);
        int ld_idx;
        int st_idx;
        ld_idx = -1;
        st_idx = -1;
        if (r_kind[a] == 1'b0) ld_idx = a;
        else st_idx = a;
        if (b >= 0) begin
            if (r_kind[b] == 1'b0) ld_idx = b;
            else st_idx = b;
        end
        if (ld_idx >= 0) begin
            ld_addr  = r_addr[ld_idx];
            ld_robid = r_robid[ld_idx];
            ld_preg  = r_preg[ld_idx];
            ld_valid = 1'b1;
        end
        if (st_idx >= 0) begin
            st_addr  = r_addr[st_idx];
            st_robid = r_robid[st_idx];
            st_valid = 1'b1;
        end
        while (ld_valid || st_valid) begin
            @(negedge clk);
            if (ld_valid && ld_ready) begin
                sb_idx.push_back(ld_idx);
                sb_cyc.push_back(cyc + 1);
                ld_idx = -1;
            end
            if (st_valid && st_ready) begin
                sb_idx.push_back(st_idx);
                sb_cyc.push_back(cyc + 1);
                st_idx = -1;
            end
            @(posedge clk);
            #DRIVE_DLY;
            if (ld_idx < 0) ld_valid = 1'b0;
            if (st_idx < 0) st_valid = 1'b0;
        end
    endtask

    // Completion scoreboard
    initial begin
        int   idx;
        int   acc;
        logic exp_wb;
        forever begin
            @(negedge clk);
            if (arst_n && cpl_valid) begin
                if (sb_idx.size() == 0) begin
                    $display("Completion for ROB id %0h with no request in flight", cpl_robid);
                    $display("TEST FAILED");
                    $fatal(1, "unexpected completion");
                end else begin
                    idx    = sb_idx.pop_front();
                    acc    = sb_cyc.pop_front();
                    exp_wb = (r_kind[idx] == 1'b0) && e_hit[idx];
                    check_value("cpl_valid latency", 64'(cyc - acc), 64'(LATENCY));
                    check_value("cpl_robid", 64'(cpl_robid), 64'(r_robid[idx]));
                    check_value("cpl_hit", 64'(cpl_hit), 64'(e_hit[idx]));
                    check_value("cpl_is_load", 64'(cpl_is_load), 64'(r_kind[idx] == 1'b0));
                    check_value("wb_valid", 64'(wb_valid), 64'(exp_wb));
                    if (exp_wb) begin
                        check_value("wb_preg", 64'(wb_preg), 64'(r_preg[idx]));
                        check_value("wb_data", wb_data, e_data[idx]);
                    end
                end
            end else if (arst_n) begin
                check_value("wb_valid", 64'(wb_valid), 64'd0);
            end
        end
    end

    initial begin
        wait (loaded);
        #(n_records * CYCLES_PER_RECORD * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles",
                 n_records * CYCLES_PER_RECORD);
        $display("TEST FAILED");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        int i;
        arst_n     = 1'b0;
        ld_valid   = 1'b0;
        ld_addr    = '0;
        ld_robid   = '0;
        ld_preg    = '0;
        st_valid   = 1'b0;
        st_addr    = '0;
        st_robid   = '0;
        fill_valid = 1'b0;
        fill_set   = '0;
        fill_way   = '0;
        fill_tag   = '0;
        fill_state = l1_cache_pkg::MESI_I;
        fill_line  = '0;
        lfsr_state = 8'd3;
        n_ops      = 0;
        n_records  = 0;
        n_pairs    = 0;
        load_golden();
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;

        // Idle outputs out of reset
        @(negedge clk);
        check_value("fill_ready", 64'(fill_ready), 64'd1);
        check_value("cpl_valid", 64'(cpl_valid), 64'd0);
        check_value("ld_ready", 64'(ld_ready), 64'd0);
        check_value("st_ready", 64'(st_ready), 64'd0);
        @(posedge clk);
        #DRIVE_DLY;

        i = 0;
        while (i < n_ops) begin
            if (op_type[i] == "F") begin
                apply_fill(i);
                i++;
            end else begin
                if (r_sync[i] == 2'd0) begin
                    idle_gap();
                end
                if (r_sync[i] == 2'd2) begin
                    if (i + 1 >= n_ops || op_type[i+1] != "R" || r_kind[i+1] == r_kind[i]) begin
                        golden_error("paired request needs a following R of the other kind");
                    end
                    send_requests(i, i + 1);
                    i += 2;
                end else begin
                    send_requests(i, -1);
                    i++;
                end
            end
        end

        repeat (LATENCY + 2) @(posedge clk);
        #DRIVE_DLY;
        check_value("cnt_st_blocked", 64'(cnt_st_blocked), 64'(n_pairs));
        if (sb_idx.size() != 0) begin
            $display("Run ended with %0d completions missing", sb_idx.size());
            $display("TEST FAILED");
            $fatal(1, "missing completions");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+src
src/rob_pkg.sv
src/l1_cache_pkg.sv
src/l1_array_if.sv
src/mem_req_arbiter.sv
src/l1_set_arrays.sv
src/mempipe.sv
src/l1_dcache_top.sv
bench/tb_l1_dcache.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    --top-module tb_l1_dcache \
    -f compile.f \
    -Mdir obj_dir \
    -o sim_l1_dcache
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_l1_dcache
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit "$status"
fi

exit 0

//--- bench/l1_golden.txt
# F set way tag state(0=I 1=S 2=E 3=M) line
# R kind(0=ld 1=st) addr robid preg sync(0=gap 1=b2b 2=with next R), then E hit data
# Loads to every set straight out of reset
R 0 0000 00 10 0 E 0 0  R 0 0010 01 11 1 E 0 0
R 0 0020 02 12 1 E 0 0  R 0 0030 03 13 1 E 0 0
R 0 0040 04 14 1 E 0 0  R 0 0050 05 15 1 E 0 0
R 0 0060 06 16 1 E 0 0  R 0 0070 07 17 1 E 0 0
R 0 0080 08 18 1 E 0 0  R 0 0090 09 19 1 E 0 0
R 0 00a0 0a 1a 1 E 0 0  R 0 00b0 0b 1b 1 E 0 0
R 0 00c0 0c 1c 1 E 0 0  R 0 00d0 0d 1d 1 E 0 0
R 0 00e0 0e 1e 1 E 0 0  R 0 00f0 0f 1f 1 E 0 0
# Fills
F 3 1 5a 1 0f0e0d0c0b0a09080706050403020100
F 3 2 5b 0 ffffffffffffffffffffffffffffffff
F 7 0 c4 2 afaeadacabaaa9a8a7a6a5a4a3a2a1a0
F 7 3 c5 3 5f5e5d5c5b5a59585756555453525150
# Load hits with wrap past byte 15
R 0 5a3c 20 21 0 E 1 030201000f0e0d0c
R 0 c479 21 22 0 E 1 a0afaeadacabaaa9
R 0 c57f 22 23 0 E 1 565554535251505f
# Load misses, tag on an invalid way and no tag at all
R 0 5b30 23 24 0 E 0 0
R 0 9930 24 25 0 E 0 0
# Store ownership, S misses, E and M hit
R 1 5a30 25 00 0 E 0 0
R 1 c470 26 00 0 E 1 0
R 1 c578 27 00 0 E 1 0
# Load and store valid together
R 0 5a30 28 29 2 E 1 0706050403020100
R 1 c574 29 00 0 E 1 0
# Five back to back
R 0 c473 30 31 0 E 1 aaa9a8a7a6a5a4a3
R 0 c578 31 32 1 E 1 5f5e5d5c5b5a5958
R 1 c470 32 00 1 E 1 0
R 0 5a34 33 34 1 E 1 0b0a090807060504
R 0 0000 34 35 1 E 0 0
